// File: rtl/obstacle_pkg.sv
package obstacle_pkg;

    typedef logic [15:0]        obstacle_t;
    typedef logic [2:0]         obstacle_kind_t;
    typedef logic [1:0]         lane_t;
    typedef logic signed [11:0] depth_t;       // far end of the obstacle with msb always 0
    typedef logic signed [15:0] coord_t;
    typedef logic [47:0]        vertex_t;      // {x, y, z}
    typedef logic [15:0]        color_t;
    typedef logic [4:0]         vertex_idx_t;
    typedef logic [4:0]         vertex_cnt_t;
    typedef logic               edge_sel_t;

    // obstacle type field
    localparam obstacle_kind_t KIND_LOW_BARRIER  = 3'd1;
    localparam obstacle_kind_t KIND_HIGH_BARRIER = 3'd2;
    localparam obstacle_kind_t KIND_MID_BARRIER  = 3'd3;
    localparam obstacle_kind_t KIND_TRAIN_CAR    = 3'd4;

    // lane edges in x
    localparam coord_t LEFT_LANE_LEFT   = -128;
    localparam coord_t LEFT_LANE_RIGHT  = -64;
    localparam coord_t MID_LANE_LEFT    = -32;
    localparam coord_t MID_LANE_RIGHT   = 32;
    localparam coord_t RIGHT_LANE_LEFT  = 64;
    localparam coord_t RIGHT_LANE_RIGHT = 128;

    // screen y grows downward
    localparam coord_t Y_GROUND     = 128;
    localparam coord_t Y_MID        = 96;
    localparam coord_t Y_TOP        = 64;
    localparam coord_t MID_BAR_HALF = 8;

    localparam coord_t MIN_Z             = 8;
    localparam coord_t BARRIER_THICKNESS = 32;
    localparam coord_t CAR_LENGTH        = 128;

    localparam vertex_cnt_t BARRIER_VERTS = 5'd6;   // two triangles
    localparam vertex_cnt_t CAR_VERTS     = 5'd24;  // eight triangles

    localparam color_t COLOR_BARRIER   = 16'hF000;
    localparam color_t COLOR_CAR_FRONT = 16'h001F;
    localparam color_t COLOR_CAR_LEFT  = 16'h000F;
    localparam color_t COLOR_CAR_RIGHT = 16'h000A;
    localparam color_t COLOR_CAR_TOP   = 16'h312F;

    // edge selector values
    localparam edge_sel_t EDGE_LEFT  = 1'b0;
    localparam edge_sel_t EDGE_RIGHT = 1'b1;
    localparam edge_sel_t EDGE_BASE  = 1'b0;
    localparam edge_sel_t EDGE_PEAK  = 1'b1;
    localparam edge_sel_t EDGE_NEAR  = 1'b0;
    localparam edge_sel_t EDGE_FAR   = 1'b1;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_GEN
    } seq_state_e;

endpackage

// File: rtl/obstacle_decoder.sv
`timescale 1ns/1ps

module obstacle_decoder (
    input  logic                         clk,
    input  logic                         rst,
    input  obstacle_pkg::obstacle_t      obstacle,
    input  logic                         accept,
    output obstacle_pkg::obstacle_kind_t kind,
    output obstacle_pkg::coord_t         lane_left,
    output obstacle_pkg::coord_t         lane_right,
    output obstacle_pkg::coord_t         y_base,
    output obstacle_pkg::coord_t         y_peak,
    output obstacle_pkg::coord_t         z_near,
    output obstacle_pkg::coord_t         z_far,
    output obstacle_pkg::vertex_cnt_t    shape_len
);
    import obstacle_pkg::*;

    obstacle_kind_t obs_kind;
    lane_t          obs_lane;
    depth_t         obs_depth;
    coord_t         depth_c;
    coord_t         left_c;
    coord_t         right_c;
    coord_t         base_c;
    coord_t         peak_c;
    coord_t         near_c;
    vertex_cnt_t    len_c;

    assign obs_kind  = obstacle[15:13];
    assign obs_lane  = obstacle[12:11];
    assign obs_depth = {1'b0, obstacle[10:0]};
    assign depth_c   = coord_t'(obs_depth);

    always_comb begin
        case (obs_lane)
            2'd0: begin
                left_c  = LEFT_LANE_LEFT;
                right_c = LEFT_LANE_RIGHT;
            end
            2'd1: begin
                left_c  = MID_LANE_LEFT;
                right_c = MID_LANE_RIGHT;
            end
            default: begin  // codes 2 and 3 are both the right lane
                left_c  = RIGHT_LANE_LEFT;
                right_c = RIGHT_LANE_RIGHT;
            end
        endcase
    end

    always_comb begin
        base_c = Y_GROUND;
        peak_c = Y_TOP;
        near_c = depth_c - BARRIER_THICKNESS;
        len_c  = '0;
        case (obs_kind)
            KIND_LOW_BARRIER: begin
                peak_c = Y_MID;
                len_c  = (depth_c < BARRIER_THICKNESS + MIN_Z) ? 5'd0 : BARRIER_VERTS;
            end
            KIND_HIGH_BARRIER: begin
                base_c = Y_MID;
                len_c  = (depth_c < BARRIER_THICKNESS + MIN_Z) ? 5'd0 : BARRIER_VERTS;
            end
            KIND_MID_BARRIER: begin
                base_c = Y_MID + MID_BAR_HALF;
                peak_c = Y_MID - MID_BAR_HALF;
                len_c  = (depth_c < BARRIER_THICKNESS + MIN_Z) ? 5'd0 : BARRIER_VERTS;
            end
            KIND_TRAIN_CAR: begin
                near_c = depth_c - CAR_LENGTH;  // near end may go negative and is clamped later
                len_c  = CAR_VERTS;
            end
            default: len_c = '0;  // nothing to draw
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            kind      <= '0;
            shape_len <= '0;
        end else if (accept) begin
            kind      <= obs_kind;
            shape_len <= len_c;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            lane_left  <= left_c;
            lane_right <= right_c;
            y_base     <= base_c;
            y_peak     <= peak_c;
            z_near     <= near_c;
            z_far      <= depth_c;
        end
    end

endmodule

// File: rtl/shape_table.sv
`timescale 1ns/1ps

module shape_table (
    input  obstacle_pkg::obstacle_kind_t kind,
    input  obstacle_pkg::vertex_idx_t    vertex_idx,
    output obstacle_pkg::edge_sel_t      x_sel,
    output obstacle_pkg::edge_sel_t      y_sel,
    output obstacle_pkg::edge_sel_t      z_sel,
    output obstacle_pkg::color_t         vertex_color
);
    import obstacle_pkg::*;

    vertex_idx_t rel_idx;
    logic [1:0]  face_grp;   // front, left side, right side, top
    logic [2:0]  face_pos;   // 0..5 within the group
    edge_sel_t   front_x;
    edge_sel_t   front_y;
    edge_sel_t   side_y;
    edge_sel_t   side_z;
    edge_sel_t   top_x;
    edge_sel_t   top_z;

    always_comb begin
        if (vertex_idx < 5'd6) begin
            face_grp = 2'd0;
            rel_idx  = vertex_idx;
        end else if (vertex_idx < 5'd12) begin
            face_grp = 2'd1;
            rel_idx  = vertex_idx - 5'd6;
        end else if (vertex_idx < 5'd18) begin
            face_grp = 2'd2;
            rel_idx  = vertex_idx - 5'd12;
        end else begin
            face_grp = 2'd3;
            rel_idx  = vertex_idx - 5'd18;
        end
        face_pos = rel_idx[2:0];
    end

    // recipes for one quad as two triangles
    always_comb begin
        front_x = EDGE_LEFT;
        front_y = EDGE_BASE;
        side_y  = EDGE_PEAK;
        side_z  = EDGE_NEAR;
        top_x   = EDGE_LEFT;
        top_z   = EDGE_NEAR;
        case (face_pos)
            3'd1: begin
                front_x = EDGE_RIGHT;
                side_z  = EDGE_FAR;
                top_x   = EDGE_RIGHT;
            end
            3'd2: begin
                front_y = EDGE_PEAK;
                side_y  = EDGE_BASE;
                top_x   = EDGE_RIGHT;
                top_z   = EDGE_FAR;
            end
            3'd3: begin
                front_x = EDGE_RIGHT;
                side_y  = EDGE_BASE;
                top_x   = EDGE_RIGHT;
                top_z   = EDGE_FAR;
            end
            3'd4: begin
                front_x = EDGE_RIGHT;
                front_y = EDGE_PEAK;
                side_z  = EDGE_FAR;
                top_z   = EDGE_FAR;
            end
            3'd5: begin
                front_y = EDGE_PEAK;
                side_y  = EDGE_BASE;
                side_z  = EDGE_FAR;
            end
            default: ;  // position 0 is the default recipe
        endcase
    end

    always_comb begin
        x_sel        = front_x;
        y_sel        = front_y;
        z_sel        = EDGE_NEAR;
        vertex_color = COLOR_BARRIER;
        if (kind == KIND_TRAIN_CAR) begin
            case (face_grp)
                2'd0: vertex_color = COLOR_CAR_FRONT;
                2'd1: begin
                    x_sel        = EDGE_LEFT;
                    y_sel        = side_y;
                    z_sel        = side_z;
                    vertex_color = COLOR_CAR_LEFT;
                end
                2'd2: begin
                    x_sel        = EDGE_RIGHT;
                    y_sel        = side_y;
                    z_sel        = side_z;
                    vertex_color = COLOR_CAR_RIGHT;
                end
                default: begin
                    x_sel        = top_x;
                    y_sel        = EDGE_PEAK;
                    z_sel        = top_z;
                    vertex_color = COLOR_CAR_TOP;
                end
            endcase
        end
    end

endmodule

// File: rtl/vertex_builder.sv
`timescale 1ns/1ps

module vertex_builder (
    input  logic                    clk,
    input  logic                    emit,
    input  obstacle_pkg::coord_t    lane_left,
    input  obstacle_pkg::coord_t    lane_right,
    input  obstacle_pkg::coord_t    y_base,
    input  obstacle_pkg::coord_t    y_peak,
    input  obstacle_pkg::coord_t    z_near,
    input  obstacle_pkg::coord_t    z_far,
    input  obstacle_pkg::edge_sel_t x_sel,
    input  obstacle_pkg::edge_sel_t y_sel,
    input  obstacle_pkg::edge_sel_t z_sel,
    input  obstacle_pkg::color_t    vertex_color,
    output obstacle_pkg::vertex_t   vertex,
    output obstacle_pkg::color_t    color
);
    import obstacle_pkg::*;

    coord_t x_c;
    coord_t y_c;
    coord_t z_raw;
    coord_t z_c;

    assign x_c   = (x_sel == EDGE_RIGHT) ? lane_right : lane_left;
    assign y_c   = (y_sel == EDGE_PEAK) ? y_peak : y_base;
    assign z_raw = (z_sel == EDGE_FAR) ? z_far : z_near;

    // keep geometry in front of the near plane
    assign z_c = (z_raw < MIN_Z) ? MIN_Z : z_raw;

    always_ff @(posedge clk) begin
        if (emit) begin
            vertex <= {x_c, y_c, z_c};
            color  <= vertex_color;
        end
    end

endmodule

// File: rtl/shape_sequencer.sv
`timescale 1ns/1ps

module shape_sequencer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      obstacle_valid,
    input  logic                      done_in,
    input  obstacle_pkg::vertex_cnt_t shape_len,
    output logic                      accept,
    output logic                      emit,
    output obstacle_pkg::vertex_idx_t vertex_idx,
    output logic                      new_triangle,
    output logic                      done_out
);
    import obstacle_pkg::*;

    seq_state_e  state;
    logic        load_q;    // first GEN cycle after the decoder loads
    logic [1:0]  corner;    // 0 = first vertex of a triangle
    vertex_idx_t next_idx;
    logic        last;

    assign accept   = (state == SEQ_IDLE) && obstacle_valid;
    assign emit     = (state == SEQ_GEN) && !load_q && (vertex_idx < shape_len);
    assign next_idx = vertex_idx + 5'd1;
    assign last     = next_idx >= shape_len;  // also true for an empty shape

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= SEQ_IDLE;
            load_q     <= 1'b0;
            vertex_idx <= '0;
            corner     <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (accept) begin
                        state      <= SEQ_GEN;
                        load_q     <= 1'b1;
                        vertex_idx <= '0;
                        corner     <= '0;
                    end
                end
                SEQ_GEN: begin
                    load_q <= 1'b0;
                    if (emit) begin
                        vertex_idx <= next_idx;
                        corner     <= (corner == 2'd2) ? 2'd0 : corner + 2'd1;
                    end
                    if (!load_q && last) begin
                        state <= SEQ_IDLE;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // lines up with the vertex register in the builder
    always_ff @(posedge clk) begin
        if (rst) begin
            new_triangle <= 1'b0;
            done_out     <= 1'b0;
        end else begin
            new_triangle <= emit && (corner == 2'd0);
            done_out     <= (state == SEQ_IDLE) && done_in;  // held low while generating
        end
    end

endmodule

// File: rtl/triangle_creator.sv
`timescale 1ns/1ps

module triangle_creator (
    input  logic                    clk,
    input  logic                    rst,
    input  obstacle_pkg::obstacle_t obstacle,
    input  logic                    obstacle_valid,
    input  logic                    done_in,
    output obstacle_pkg::vertex_t   vertex,
    output obstacle_pkg::color_t    color,
    output logic                    new_triangle,
    output logic                    done_out
);
    import obstacle_pkg::*;

    logic           accept;
    logic           emit;
    vertex_cnt_t    shape_len;
    vertex_idx_t    vertex_idx;
    obstacle_kind_t kind;
    coord_t         lane_left;
    coord_t         lane_right;
    coord_t         y_base;
    coord_t         y_peak;
    coord_t         z_near;
    coord_t         z_far;
    edge_sel_t      x_sel;
    edge_sel_t      y_sel;
    edge_sel_t      z_sel;
    color_t         vertex_color;

    obstacle_decoder decoder_i (
        .clk        (clk),
        .rst        (rst),
        .obstacle   (obstacle),
        .accept     (accept),
        .kind       (kind),
        .lane_left  (lane_left),
        .lane_right (lane_right),
        .y_base     (y_base),
        .y_peak     (y_peak),
        .z_near     (z_near),
        .z_far      (z_far),
        .shape_len  (shape_len)
    );

    shape_table table_i (
        .kind         (kind),
        .vertex_idx   (vertex_idx),
        .x_sel        (x_sel),
        .y_sel        (y_sel),
        .z_sel        (z_sel),
        .vertex_color (vertex_color)
    );

    vertex_builder builder_i (
        .clk          (clk),
        .emit         (emit),
        .lane_left    (lane_left),
        .lane_right   (lane_right),
        .y_base       (y_base),
        .y_peak       (y_peak),
        .z_near       (z_near),
        .z_far        (z_far),
        .x_sel        (x_sel),
        .y_sel        (y_sel),
        .z_sel        (z_sel),
        .vertex_color (vertex_color),
        .vertex       (vertex),
        .color        (color)
    );

    shape_sequencer sequencer_i (
        .clk            (clk),
        .rst            (rst),
        .obstacle_valid (obstacle_valid),
        .done_in        (done_in),
        .shape_len      (shape_len),
        .accept         (accept),
        .emit           (emit),
        .vertex_idx     (vertex_idx),
        .new_triangle   (new_triangle),
        .done_out       (done_out)
    );

endmodule

// File: tb/triangle_creator_assert.sv
`timescale 1ns/1ps

module triangle_creator_assert (
    input logic                  clk,
    input logic                  rst,
    input obstacle_pkg::vertex_t vertex,
    input logic                  new_triangle,
    input logic                  done_out
);
    import obstacle_pkg::*;

    int unsigned fail_cnt = 0;
    coord_t      vertex_z;

    assign vertex_z = vertex[15:0];

    nt_not_back_to_back: assert property (@(posedge clk) disable iff (rst)
        new_triangle |=> !new_triangle)
        else begin
            $error("new_triangle high on two consecutive cycles");
            fail_cnt++;
        end

    // frame end only reported while idle
    done_not_with_nt: assert property (@(posedge clk) disable iff (rst)
        !(done_out && new_triangle))
        else begin
            $error("done_out and new_triangle high together");
            fail_cnt++;
        end

    z_above_near_plane: assert property (@(posedge clk) disable iff (rst)
        new_triangle |-> vertex_z >= MIN_Z)
        else begin
            $error("vertex z below the near plane at a triangle start");
            fail_cnt++;
        end

endmodule

bind triangle_creator triangle_creator_assert props_i (
    .clk          (clk),
    .rst          (rst),
    .vertex       (vertex),
    .new_triangle (new_triangle),
    .done_out     (done_out)
);

// File: tb/triangle_creator_tb.sv
`timescale 1ns/1ps

module triangle_creator_tb;
    import obstacle_pkg::*;

    logic      clk = 1'b0;
    logic      rst;
    obstacle_t obstacle;
    logic      obstacle_valid;
    logic      done_in;
    vertex_t   vertex;
    color_t    color;
    logic      new_triangle;
    logic      done_out;

    // records from the stimulus file
    string       names[$];
    obstacle_t   words[$];
    logic        dones[$];
    vertex_cnt_t tri_counts[$];
    vertex_t     exp_verts[$];   // three per triangle
    color_t      exp_colors[$];  // one per triangle

    int cycles = 0;
    int cycle_limit = 1000;

    triangle_creator dut_i (
        .clk            (clk),
        .rst            (rst),
        .obstacle       (obstacle),
        .obstacle_valid (obstacle_valid),
        .done_in        (done_in),
        .vertex         (vertex),
        .color          (color),
        .new_triangle   (new_triangle),
        .done_out       (done_out)
    );

    always #4 clk = ~clk;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_vertex(input string test, input vertex_t exp, input vertex_t act);
        if (act !== exp) begin
            fail_run($sformatf("Error: %s expected %h actual %h", test, exp, act));
        end
    endtask

    task automatic check_color(input string test, input color_t exp, input color_t act);
        if (act !== exp) begin
            fail_run($sformatf("Error: %s expected %h actual %h", test, exp, act));
        end
    endtask

    task automatic check_count(input string test, input vertex_cnt_t exp, input vertex_cnt_t act);
        if (act !== exp) begin
            fail_run($sformatf("Error: %s expected %0d actual %0d", test, exp, act));
        end
    endtask

    task automatic check_flag(input string test, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("Error: %s expected %b actual %b", test, exp, act));
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            fail_run($sformatf("Timeout, the run did not finish within %0d cycles", cycle_limit));
        end
    end

    task automatic load_stimulus();
        int        fd;
        int        left;
        int        done_val;
        int        cnt;
        string     line;
        string     name;
        obstacle_t word;
        vertex_t   v0;
        vertex_t   v1;
        vertex_t   v2;
        color_t    c;
        left = 0;
        fd = $fopen("tb/triangle_creator_stimulus.txt", "r");
        if (fd == 0) begin
            fail_run("Could not open the stimulus file");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;  // blank or comment
            end
            if (left == 0) begin
                if ($sscanf(line, "%s %h %d %d", name, word, done_val, cnt) != 4) begin
                    fail_run({"Bad record line in the stimulus file: ", line});
                end
                names.push_back(name);
                words.push_back(word);
                dones.push_back(done_val[0]);
                tri_counts.push_back(vertex_cnt_t'(cnt));
                left = cnt;
            end else begin
                if ($sscanf(line, "%h %h %h %h", v0, v1, v2, c) != 4) begin
                    fail_run({"Bad triangle line in the stimulus file: ", line});
                end
                exp_verts.push_back(v0);
                exp_verts.push_back(v1);
                exp_verts.push_back(v2);
                exp_colors.push_back(c);
                left--;
            end
        end
        $fclose(fd);
    endtask

    task automatic run_record(input int r, input int tri_base);
        string       name;
        int          len;
        int          idx;
        int          k;
        vertex_cnt_t seen;
        name = names[r];
        len  = 3 * tri_counts[r];
        seen = '0;
        @(posedge clk);
        done_in        <= dones[r];
        obstacle_valid <= 1'b0;
        @(posedge clk);
        obstacle       <= words[r];
        obstacle_valid <= 1'b1;
        @(negedge clk);
        check_flag({name, " done_out while idle"}, dones[r], done_out);
        @(posedge clk);
        obstacle_valid <= 1'b0;  // strobe taken at this edge
        for (k = 1; k <= len + 2; k++) begin
            @(posedge clk);
            if (len > 0) begin
                obstacle       <= 16'h2880;  // stray low barrier mid shape
                obstacle_valid <= (k == 4);
            end
            @(negedge clk);
            idx  = k - 2;
            seen = seen + vertex_cnt_t'(new_triangle);
            if (k <= len + 1) begin
                check_flag({name, " done_out while generating"}, 1'b0, done_out);
            end
            if (idx >= 0 && idx < len) begin
                check_flag($sformatf("%s new_triangle %0d", name, idx), (idx % 3) == 0,
                           new_triangle);
                check_vertex($sformatf("%s vertex %0d", name, idx),
                             exp_verts[3 * tri_base + idx], vertex);
                check_color($sformatf("%s color %0d", name, idx),
                            exp_colors[tri_base + idx / 3], color);
            end
        end
        check_count({name, " triangle count"}, tri_counts[r], seen);
    endtask

    initial begin
        int r;
        int tri_base;
        rst            = 1'b1;
        obstacle       = '0;
        obstacle_valid = 1'b0;
        done_in        = 1'b0;
        load_stimulus();
        cycle_limit = 30 * names.size() + 20;
        tri_base    = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (r = 0; r < names.size(); r++) begin
            run_record(r, tri_base);
            tri_base += tri_counts[r];
        end
        // sequencer back in idle after the last record
        @(posedge clk);
        done_in <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_flag("end_of_run done_out while idle", 1'b1, done_out);
        @(posedge clk);
        if (dut_i.props_i.fail_cnt != 0) begin
            fail_run("One or more output assertions fired during the run");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

// File: tb/triangle_creator_stimulus.txt
# record line is name, obstacle word (hex), done_in, triangle count
# then one line per triangle with three vertices {x,y,z} and the color, all hex
low_lane0 20c8 0 2
ff80008000a8 ffc0008000a8 ff80006000a8 f000
ffc0008000a8 ffc0006000a8 ff80006000a8 f000
high_lane1_edge 4828 1 2
ffe000600008 002000600008 ffe000400008 f000
002000600008 002000400008 ffe000400008 f000
mid_lane2 73e8 0 2
0040006803c8 0080006803c8 0040005803c8 f000
0080006803c8 0080005803c8 0040005803c8 f000
low_lane3 3fff 0 2
0040008007df 0080008007df 0040006007df f000
0080008007df 0080006007df 0040006007df f000
high_culled 4027 1 0
car_far 8c00 0 8
ffe000800380 002000800380 ffe000400380 001f
002000800380 002000400380 ffe000400380 001f
ffe000400380 ffe000400400 ffe000800380 000f
ffe000800380 ffe000400400 ffe000800400 000f
002000400380 002000400400 002000800380 000a
002000800380 002000400400 002000800400 000a
ffe000400380 002000400380 002000400400 312f
002000400400 ffe000400400 ffe000400380 312f
car_clamped 8064 1 8
ff8000800008 ffc000800008 ff8000400008 001f
ffc000800008 ffc000400008 ff8000400008 001f
ff8000400008 ff8000400064 ff8000800008 000f
ff8000800008 ff8000400064 ff8000800064 000f
ffc000400008 ffc000400064 ffc000800008 000a
ffc000800008 ffc000400064 ffc000800064 000a
ff8000400008 ffc000400008 ffc000400064 312f
ffc000400064 ff8000400064 ff8000400008 312f
kind0_empty 0c80 1 0
kind5_empty b200 0 0
kind6_empty d900 1 0

// File: triangle_creator.f
rtl/obstacle_pkg.sv
rtl/obstacle_decoder.sv
rtl/shape_table.sv
rtl/vertex_builder.sv
rtl/shape_sequencer.sv
rtl/triangle_creator.sv
tb/triangle_creator_assert.sv
tb/triangle_creator_tb.sv

// File: Bender.yml
package:
  name: triangle_creator

sources:
  - rtl/obstacle_pkg.sv
  - rtl/obstacle_decoder.sv
  - rtl/shape_table.sv
  - rtl/vertex_builder.sv
  - rtl/shape_sequencer.sv
  - rtl/triangle_creator.sv
  - target: test
    files:
      - tb/triangle_creator_assert.sv
      - tb/triangle_creator_tb.sv
